// ==== common/eth_rx_pkg.sv ====
package eth_rx_pkg;

	//////////////////////////////////////////////////////////////
	// Framing and CRC constants

	// Width of each performance counter
	localparam int COUNTER_WIDTH = 16;

	// Preamble filler byte and start-of-frame delimiter
	localparam logic [7:0] GMII_PREAMBLE = 8'h55;
	localparam logic [7:0] GMII_SFD = 8'hd5;

	// Reflected Ethernet CRC-32 polynomial and seed
	localparam logic [31:0] CRC32_POLY = 32'hedb88320;
	localparam logic [31:0] CRC32_INIT = 32'hffffffff;

	// Trailing FCS length in bytes
	localparam int FCS_BYTES = 4;

	//////////////////////////////////////////////////////////////
	// Bus and state types

	// One GMII receive beat, 11 bits
	// dvalid qualifies the byte at 10/100
	typedef struct packed {
		logic dvalid;
		logic en;
		logic er;
		logic [7:0] data;
	} gmii_bus_t;

	// Word stream to the upper layer, 39 bits
	// First byte of the word sits in data[31:24]
	typedef struct packed {
		logic start;
		logic data_valid;
		logic [2:0] bytes_valid;
		logic [31:0] data;
		logic commit;
		logic drop;
	} eth_rx_bus_t;

	// Receive FSM states
	typedef enum logic [2:0] {
		RX_IDLE,
		RX_PREAMBLE,
		RX_FRAME_DATA,
		RX_CHECK,
		RX_DROP
	} rx_state_t;

	// Good and bad frame counts
	typedef struct packed {
		logic [COUNTER_WIDTH-1:0] rx_frames;
		logic [COUNTER_WIDTH-1:0] rx_crc_err;
	} rx_perf_counters_t;

endpackage

// ==== crc/crc32_ethernet.sv ====
`timescale 1ns/1ns

module crc32_ethernet (
	input logic gmii_rx_clk,
	input logic reset,
	input logic clear,
	input logic update,
	input logic [7:0] din,
	output logic [31:0] crc_value
);
	import eth_rx_pkg::*;

	logic [31:0] crc_reg;

	// Fold one byte into the running CRC, LSB first
	function automatic logic [31:0] crc_next(input logic [31:0] crc, input logic [7:0] d);
		logic [31:0] c;
		c = crc;
		for (int i = 0; i < 8; i++) begin
			if (c[0] ^ d[i])
				c = (c >> 1) ^ CRC32_POLY;
			else
				c = c >> 1;
		end
		return c;
	endfunction

	// Clear wins over update, SFD never carries payload
	always_ff @(posedge gmii_rx_clk) begin
		if (reset || clear)
			crc_reg <= CRC32_INIT;
		else if (update)
			crc_reg <= crc_next(crc_reg, din);
	end

	// Final complement, ready for the FCS compare
	assign crc_value = ~crc_reg;

endmodule

// ==== project.f ====
common/eth_rx_pkg.sv
crc/crc32_ethernet.sv
rx_mac/eth_rx_mac.sv
verilog/rx_perf_counters.sv
verilog/eth_rx_top.sv
sim/eth_rx_properties.sv
sim/eth_rx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the GMII receive testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module eth_rx_tb \
	-f project.f -o eth_rx_sim > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }

(./obj_dir/eth_rx_sim > sim.log 2>&1 || true) \
	&& grep -q "^Verification passed$" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL, see sim.log"; exit 1; }

// ==== rx_mac/eth_rx_mac.sv ====
`timescale 1ns/1ns

module eth_rx_mac (
	input logic gmii_rx_clk,
	input logic reset,
	input logic link_up,
	input eth_rx_pkg::gmii_bus_t gmii_rx_bus,
	input logic [31:0] crc_value,
	output logic crc_clear,
	output logic crc_update,
	output logic [7:0] crc_din,
	output eth_rx_pkg::eth_rx_bus_t rx_bus
);
	import eth_rx_pkg::*;

	rx_state_t state;

	// Hold-back line, newest byte in [7:0], oldest in [31:24]
	logic [31:0] hold_line;
	logic [2:0] hold_count;

	// Word packer, bytes shift in at the low end
	logic [31:0] pack_data;
	logic [1:0] pack_count;

	// er seen inside the frame body
	logic frame_err;

	logic byte_valid;
	logic hold_full;
	logic sfd_seen;
	logic [7:0] pop_byte;
	logic [31:0] fcs_rx;

	//////////////////////////////////////////////////////////////
	// Byte qualifiers

	assign byte_valid = gmii_rx_bus.dvalid && gmii_rx_bus.en;
	assign hold_full = (hold_count == 3'(FCS_BYTES));

	// SFD may follow the preamble or open the envelope directly
	assign sfd_seen = byte_valid && !gmii_rx_bus.er && (gmii_rx_bus.data == GMII_SFD) &&
		((state == RX_IDLE) || (state == RX_PREAMBLE));

	// Byte leaving the hold-back line, payload only
	assign pop_byte = hold_line[31:24];

	// FCS is sent little-endian, first byte is the LSB
	assign fcs_rx = {hold_line[7:0], hold_line[15:8], hold_line[23:16], hold_line[31:24]};

	//////////////////////////////////////////////////////////////
	// CRC unit control

	// Seed on the SFD
	assign crc_clear = sfd_seen;

	// Same edge as the packer so the CRC is complete at end of frame
	assign crc_update = (state == RX_FRAME_DATA) && byte_valid && hold_full;
	assign crc_din = pop_byte;

	//////////////////////////////////////////////////////////////
	// Receive FSM, hold-back line and packer

	always_ff @(posedge gmii_rx_clk) begin
		// Pulses last a single cycle
		rx_bus.start <= 1'b0;
		rx_bus.data_valid <= 1'b0;
		rx_bus.commit <= 1'b0;
		rx_bus.drop <= 1'b0;

		if (reset) begin
			state <= RX_IDLE;
			hold_count <= '0;
			pack_count <= '0;
			frame_err <= 1'b0;
		end else if (!link_up) begin
			// Link loss aborts a frame already announced by start
			if ((state == RX_FRAME_DATA) || (state == RX_CHECK))
				rx_bus.drop <= 1'b1;
			state <= RX_IDLE;
		end else begin
			case (state)
				// Hunt for preamble, then the SFD
				RX_IDLE, RX_PREAMBLE: begin
					if (gmii_rx_bus.dvalid) begin
						if (!gmii_rx_bus.en)
							state <= RX_IDLE;
						else if (sfd_seen) begin
							rx_bus.start <= 1'b1;
							hold_count <= '0;
							pack_count <= '0;
							frame_err <= 1'b0;
							state <= RX_FRAME_DATA;
						end else if (!gmii_rx_bus.er && (gmii_rx_bus.data == GMII_PREAMBLE))
							state <= RX_PREAMBLE;
						else
							// Bad preamble byte or er, silent until en falls
							state <= RX_DROP;
					end
				end

				RX_FRAME_DATA: begin
					if (gmii_rx_bus.dvalid) begin
						if (!gmii_rx_bus.en) begin
							// End of frame, flush any partial word
							state <= RX_CHECK;
							if (pack_count != 2'd0) begin
								rx_bus.data_valid <= 1'b1;
								rx_bus.bytes_valid <= {1'b0, pack_count};
								case (pack_count)
									2'd1: rx_bus.data <= {pack_data[7:0], 24'h0};
									2'd2: rx_bus.data <= {pack_data[15:0], 16'h0};
									default: rx_bus.data <= {pack_data[23:0], 8'h0};
								endcase
							end
						end else begin
							hold_line <= {hold_line[23:0], gmii_rx_bus.data};
							if (gmii_rx_bus.er)
								frame_err <= 1'b1;

							if (!hold_full)
								// Still filling, nothing pops yet
								hold_count <= hold_count + 3'd1;
							else begin
								pack_data <= {pack_data[23:0], pop_byte};
								pack_count <= pack_count + 2'd1;
								// Fourth byte completes a word
								if (pack_count == 2'd3) begin
									rx_bus.data_valid <= 1'b1;
									rx_bus.bytes_valid <= 3'd4;
									rx_bus.data <= {pack_data[23:0], pop_byte};
								end
							end
						end
					end
				end

				// One cycle after the flush, independent of dvalid
				RX_CHECK: begin
					state <= RX_IDLE;
					// Runts never fill the line and are dropped
					if (hold_full && !frame_err && (crc_value == fcs_rx))
						rx_bus.commit <= 1'b1;
					else
						rx_bus.drop <= 1'b1;
				end

				// Discard the rest of a bad frame
				RX_DROP: begin
					if (gmii_rx_bus.dvalid && !gmii_rx_bus.en)
						state <= RX_IDLE;
				end

				default: state <= RX_IDLE;
			endcase
		end
	end

endmodule

// ==== sim/eth_rx_properties.sv ====
`timescale 1ns/1ns

module eth_rx_properties (
	input logic gmii_rx_clk,
	input logic reset,
	input eth_rx_pkg::eth_rx_bus_t rx_bus
);

	// High between start and the closing commit or drop
	logic in_frame;

	always_ff @(posedge gmii_rx_clk) begin
		if (reset)
			in_frame <= 1'b0;
		else if (rx_bus.start)
			in_frame <= 1'b1;
		else if (rx_bus.commit || rx_bus.drop)
			in_frame <= 1'b0;
	end

	//////////////////////////////////////////////////////////////
	// Receive bus rules

	commit_drop_excl: assert property (@(posedge gmii_rx_clk) disable iff (reset)
		!(rx_bus.commit && rx_bus.drop))
		else $error("commit and drop high together");

	bytes_valid_range: assert property (@(posedge gmii_rx_clk) disable iff (reset)
		rx_bus.data_valid |-> (rx_bus.bytes_valid >= 3'd1 && rx_bus.bytes_valid <= 3'd4))
		else $error("bytes_valid out of range");

	data_in_frame: assert property (@(posedge gmii_rx_clk) disable iff (reset)
		rx_bus.data_valid |-> in_frame)
		else $error("data word outside a frame");

	// Pulses cleared by reset
	reset_quiet: assert property (@(posedge gmii_rx_clk)
		reset |=> !(rx_bus.start || rx_bus.data_valid || rx_bus.commit || rx_bus.drop))
		else $error("pulse high right after reset");

endmodule

bind eth_rx_top eth_rx_properties u_props (
	.gmii_rx_clk(gmii_rx_clk),
	.reset(reset),
	.rx_bus(rx_bus)
);

// ==== sim/eth_rx_tb.sv ====
`timescale 1ns/1ns

module eth_rx_tb;
	import eth_rx_pkg::*;

	// Kinds of events seen on the receive bus
	typedef enum logic [1:0] {
		EV_START,
		EV_DATA,
		EV_COMMIT,
		EV_DROP
	} ev_kind_t;

	typedef struct packed {
		ev_kind_t kind;
		logic [2:0] bytes_valid;
		logic [31:0] data;
	} exp_event_t;

	logic gmii_rx_clk;
	logic reset;
	logic link_up;
	gmii_bus_t gmii_rx_bus;
	eth_rx_bus_t rx_bus;
	rx_perf_counters_t perf;

	int seed;
	int good_count;
	int bad_count;
	bit use_gaps;
	// Payload then FCS bytes following the SFD
	logic [7:0] frame_q[$];
	exp_event_t exp_q[$];

	eth_rx_top dut (
		.gmii_rx_clk(gmii_rx_clk),
		.reset(reset),
		.link_up(link_up),
		.gmii_rx_bus(gmii_rx_bus),
		.rx_bus(rx_bus),
		.perf(perf)
	);

	initial gmii_rx_clk = 1'b0;
	always #10 gmii_rx_clk = ~gmii_rx_clk;

	//////////////////////////////////////////////////////////////
	// Error reporting

	task automatic fail_run(input string why);
		$display("ERROR at %0t: %s", $time, why);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expv,
		input logic [31:0] actv);
		$display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, expv, actv);
		$display("Verification failed");
		$fatal(1);
	endtask

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fffffff) % n;
	endfunction

	//////////////////////////////////////////////////////////////
	// Reference model

	// Reflected CRC-32 over the first n bytes of frame_q
	// Seeded with ones and complemented at the end
	function automatic logic [31:0] ref_crc(input int n);
		logic [31:0] c;
		c = 32'hffffffff;
		for (int i = 0; i < n; i++) begin
			c = c ^ {24'h0, frame_q[i]};
			for (int b = 0; b < 8; b++)
				c = c[0] ? ((c >> 1) ^ CRC32_POLY) : (c >> 1);
		end
		return ~c;
	endfunction

	// Expected events for frame_q
	// A cut of zero or more marks the byte where the link drops
	function automatic void predict(input int cut);
		exp_event_t e;
		int n_pay;
		int cnt;
		logic [31:0] fcs;
		n_pay = frame_q.size() - FCS_BYTES;
		exp_q.push_back('{EV_START, 3'd0, 32'h0});
		for (int w = 0; 4 * w < n_pay; w++) begin
			cnt = (n_pay - 4 * w > 4) ? 4 : n_pay - 4 * w;
			// Word leaves once byte 4w+7 has been sampled
			if (cut >= 0 && (cnt < 4 || 4 * w + 7 >= cut))
				break;
			e = '{EV_DATA, 3'(cnt), 32'h0};
			for (int b = 0; b < cnt; b++)
				e.data[31 - 8 * b -: 8] = frame_q[4 * w + b];
			exp_q.push_back(e);
		end
		if (cut >= 0) begin
			// Counters hold while the link is down
			exp_q.push_back('{EV_DROP, 3'd0, 32'h0});
		end else begin
			fcs = {frame_q[n_pay + 3], frame_q[n_pay + 2], frame_q[n_pay + 1], frame_q[n_pay]};
			if (ref_crc(n_pay) == fcs) begin
				exp_q.push_back('{EV_COMMIT, 3'd0, 32'h0});
				good_count++;
			end else begin
				exp_q.push_back('{EV_DROP, 3'd0, 32'h0});
				bad_count++;
			end
		end
	endfunction

	//////////////////////////////////////////////////////////////
	// Stimulus

	// Random payload with a correct FCS
	// A flip index of zero or more corrupts one bit of that byte
	task automatic build_frame(input int len, input int flip);
		logic [31:0] crc;
		frame_q.delete();
		for (int i = 0; i < len; i++)
			frame_q.push_back(8'(rand_below(256)));
		crc = ref_crc(len);
		frame_q.push_back(crc[7:0]);
		frame_q.push_back(crc[15:8]);
		frame_q.push_back(crc[23:16]);
		frame_q.push_back(crc[31:24]);
		if (flip >= 0)
			frame_q[flip] = frame_q[flip] ^ (8'h01 << rand_below(8));
	endtask

	// One byte cycle that may follow a dvalid gap
	task automatic drive_byte(input logic en, input logic er, input logic [7:0] data);
		if (use_gaps && rand_below(10) == 0) begin
			@(posedge gmii_rx_clk);
			gmii_rx_bus <= '{dvalid: 1'b0, en: en, er: 1'b0, data: 8'(rand_below(256))};
		end
		@(posedge gmii_rx_clk);
		gmii_rx_bus <= '{dvalid: 1'b1, en: en, er: er, data: data};
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge gmii_rx_clk);
			gmii_rx_bus <= '{dvalid: 1'b1, en: 1'b0, er: 1'b0, data: 8'h00};
		end
	endtask

	// pre_bad of 1 corrupts a preamble byte and 2 raises er in the preamble
	task automatic send_frame(input int pre_bad, input int cut);
		for (int i = 0; i < 7; i++)
			drive_byte(1'b1, (pre_bad == 2) && (i == 3),
				((pre_bad == 1) && (i == 3)) ? 8'h5a : GMII_PREAMBLE);
		drive_byte(1'b1, 1'b0, GMII_SFD);
		for (int i = 0; i < frame_q.size(); i++) begin
			if (i == cut) begin
				@(posedge gmii_rx_clk);
				link_up <= 1'b0;
				gmii_rx_bus <= '{dvalid: 1'b1, en: 1'b1, er: 1'b0, data: frame_q[i]};
				break;
			end
			drive_byte(1'b1, 1'b0, frame_q[i]);
		end
		if (cut < 0)
			drive_byte(1'b0, 1'b0, 8'h00);
		idle_cycles(6);
		if (cut >= 0) begin
			@(posedge gmii_rx_clk);
			link_up <= 1'b1;
			idle_cycles(2);
		end
	endtask

	// Wait for every expected event and then compare the counters
	task automatic wait_done();
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0) begin
			@(posedge gmii_rx_clk);
			cycles++;
			if (cycles > 2000)
				fail_run("timeout, commit or drop never arrived");
		end
		repeat (3) @(posedge gmii_rx_clk);
		@(negedge gmii_rx_clk);
		assert (perf.rx_frames == COUNTER_WIDTH'(good_count))
			else report_mismatch("perf.rx_frames", 32'(good_count), 32'(perf.rx_frames));
		assert (perf.rx_crc_err == COUNTER_WIDTH'(bad_count))
			else report_mismatch("perf.rx_crc_err", 32'(bad_count), 32'(perf.rx_crc_err));
	endtask

	task automatic run_frame(input int len, input int flip, input int pre_bad, input int cut);
		build_frame(len, flip);
		if (pre_bad == 0)
			predict(cut);
		send_frame(pre_bad, cut);
		wait_done();
	endtask

	//////////////////////////////////////////////////////////////
	// Output checker on the falling edge

	task automatic check_event(input ev_kind_t kind, input logic [2:0] bv,
		input logic [31:0] data);
		exp_event_t e;
		assert (exp_q.size() != 0)
			else fail_run($sformatf("unexpected %s on rx_bus", kind.name()));
		if (exp_q.size() != 0) begin
			e = exp_q.pop_front();
			assert (e.kind == kind)
				else report_mismatch("rx_bus event kind", 32'(e.kind), 32'(kind));
			if (kind == EV_DATA) begin
				assert (e.bytes_valid == bv)
					else report_mismatch("rx_bus.bytes_valid", 32'(e.bytes_valid), 32'(bv));
				assert (e.data == data)
					else report_mismatch("rx_bus.data", e.data, data);
			end
		end
	endtask

	always @(negedge gmii_rx_clk) begin
		if (!reset) begin
			if (rx_bus.start)
				check_event(EV_START, 3'd0, 32'h0);
			if (rx_bus.data_valid)
				check_event(EV_DATA, rx_bus.bytes_valid, rx_bus.data);
			if (rx_bus.commit)
				check_event(EV_COMMIT, 3'd0, 32'h0);
			if (rx_bus.drop)
				check_event(EV_DROP, 3'd0, 32'h0);
		end
	end

	//////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		seed = 78;
		good_count = 0;
		bad_count = 0;
		use_gaps = 1'b0;
		reset = 1'b1;
		link_up = 1'b1;
		gmii_rx_bus = '0;
		repeat (2) @(posedge gmii_rx_clk);
		reset <= 1'b0;
		idle_cycles(3);

		// Good frames of 1 to 70 bytes
		run_frame(1, -1, 0, -1);
		for (int i = 0; i < 12; i++)
			run_frame(1 + rand_below(70), -1, 0, -1);

		// Flipped payload byte and then flipped FCS byte
		run_frame(40, rand_below(40), 0, -1);
		run_frame(23, 23 + rand_below(4), 0, -1);

		// Bad preamble and er before the SFD between good frames
		run_frame(17, -1, 0, -1);
		run_frame(20, -1, 1, -1);
		run_frame(9, -1, 0, -1);
		run_frame(20, -1, 2, -1);
		run_frame(33, -1, 0, -1);

		// 1-in-10 dvalid gaps
		use_gaps = 1'b1;
		for (int i = 0; i < 10; i++)
			run_frame(1 + rand_below(70), -1, 0, -1);
		use_gaps = 1'b0;

		// Link lost mid frame
		run_frame(30, -1, 0, 20);
		run_frame(12, -1, 0, -1);

		$display("Verification passed");
		$finish;
	end

endmodule

// ==== verilog/eth_rx_top.sv ====
`timescale 1ns/1ns

module eth_rx_top (
	input logic gmii_rx_clk,
	input logic reset,
	input logic link_up,
	input eth_rx_pkg::gmii_bus_t gmii_rx_bus,
	output eth_rx_pkg::eth_rx_bus_t rx_bus,
	output eth_rx_pkg::rx_perf_counters_t perf
);

	// MAC to CRC unit
	logic crc_clear;
	logic crc_update;
	logic [7:0] crc_din;
	logic [31:0] crc_value;

	//////////////////////////////////////////////////////////////
	// Receive MAC

	eth_rx_mac u_mac (
		.gmii_rx_clk(gmii_rx_clk),
		.reset(reset),
		.link_up(link_up),
		.gmii_rx_bus(gmii_rx_bus),
		.crc_value(crc_value),
		.crc_clear(crc_clear),
		.crc_update(crc_update),
		.crc_din(crc_din),
		.rx_bus(rx_bus)
	);

	// Payload CRC, one byte per update
	crc32_ethernet u_crc (
		.gmii_rx_clk(gmii_rx_clk),
		.reset(reset),
		.clear(crc_clear),
		.update(crc_update),
		.din(crc_din),
		.crc_value(crc_value)
	);

	// Counters follow the frame end pulses
	rx_perf_counters u_perf (
		.gmii_rx_clk(gmii_rx_clk),
		.reset(reset),
		.link_up(link_up),
		.commit(rx_bus.commit),
		.drop(rx_bus.drop),
		.perf(perf)
	);

endmodule

// ==== verilog/rx_perf_counters.sv ====
`timescale 1ns/1ns

module rx_perf_counters (
	input logic gmii_rx_clk,
	input logic reset,
	input logic link_up,
	input logic commit,
	input logic drop,
	output eth_rx_pkg::rx_perf_counters_t perf
);
	import eth_rx_pkg::*;

	logic frames_max;
	logic crc_err_max;

	// Saturation detect
	assign frames_max = (perf.rx_frames == {COUNTER_WIDTH{1'b1}});
	assign crc_err_max = (perf.rx_crc_err == {COUNTER_WIDTH{1'b1}});

	always_ff @(posedge gmii_rx_clk) begin
		if (reset)
			perf <= '0;
		else if (link_up) begin
			// Good frames
			if (commit && !frames_max)
				perf.rx_frames <= perf.rx_frames + 1'b1;
			// FCS mismatch, runt or aborted frames
			if (drop && !crc_err_max)
				perf.rx_crc_err <= perf.rx_crc_err + 1'b1;
		end
	end

endmodule
